/* src/fx2_pkg.sv */
package fx2_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // data types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [15:0] usb_word_t;              // one 16-bit fifo word, host byte order

  typedef struct packed
  {
    logic [7:0] bin;                            // spectrum bin index
    logic [7:0] mag;                            // bin magnitude
  } spec_sample_t;

  ////////////////////////////////////////////////////////////////////////////
  // controller endpoint addressing
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [1:0] fifo_adr_t;

  localparam fifo_adr_t ep2_adr = 2'b00;        // host to device
  localparam fifo_adr_t ep4_adr = 2'b01;        // spectrum to host
  localparam fifo_adr_t ep6_adr = 2'b10;        // transmit to host

  typedef enum logic {ep_tx, ep_sp} ep_sel_t;   // source of next device-to-host burst

  typedef enum logic [4:0]
  {
    idle, from_addr, from_check,
    f1, f2, f3, f4, f5, f6, fdone,              // host word read
    to_addr, to_check,
    t1, t2, t3, t4, t5, t6, t7, tdone           // word write toward host
  } fx2_state_t;

  // the controller and the host disagree on byte order
  function automatic usb_word_t byte_swap(input usb_word_t w);
    return {w[7:0], w[15:8]};
  endfunction

endpackage

/* src/fifo_link_if.sv */
`timescale 1ns/10ps

interface fifo_link_if
#(
  parameter type payload_t = fx2_pkg::usb_word_t,
  parameter int  DEPTH     = 16
);

  localparam int UW = $clog2(DEPTH + 1);        // count reaches DEPTH

  logic           req;                          // one cycle, one word
  payload_t       data;
  logic [UW-1:0]  used;                         // words held
  logic           full;

  // fifo receives writes from the state machine
  modport wr_fifo (input req, input data, output used, output full);
  modport wr_user (output req, output data, input used, input full);

  // fifo is read by the state machine, data one cycle after req
  modport rd_fifo (input req, output data, output used, output full);
  modport rd_user (output req, input data, input used, input full);

endinterface

/* src/word_fifo.sv */
`timescale 1ns/10ps

module word_fifo
#(
  parameter type payload_t = fx2_pkg::usb_word_t,
  parameter int  DEPTH     = 16
)
(
  input  logic                         IF_clk,
  input  logic                         IF_rst,
  input  logic                         wr_req,     // write side
  input  payload_t                     wr_data,
  output logic                         full,
  input  logic                         rd_req,     // read side
  output payload_t                     rd_data,
  output logic                         empty,
  output logic [$clog2(DEPTH + 1)-1:0] used
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int UW = $clog2(DEPTH + 1);

  payload_t       mem [DEPTH];                  // circular buffer, no reset
  logic [AW-1:0]  wr_ptr;
  logic [AW-1:0]  rd_ptr;
  logic           do_wr;
  logic           do_rd;

  assign do_wr = wr_req && !full;               // overflow dropped
  assign do_rd = rd_req && !empty;
  assign full  = (used == UW'(DEPTH));          // exact, count is never stale
  assign empty = (used == '0);

  always_ff @(posedge IF_clk)
  begin
    if (do_wr)
      mem[wr_ptr] <= wr_data;
    if (do_rd)
      rd_data <= mem[rd_ptr];                   // registered read
  end

  always_ff @(posedge IF_clk)
  begin
    if (IF_rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      used   <= '0;
    end
    else
    begin
      if (do_wr)
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;   // wrap at any depth
      if (do_rd)
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10:   used <= used + 1'b1;
        2'b01:   used <= used - 1'b1;
        default: used <= used;                  // both or neither
      endcase
    end
  end

  // writer and reader live in other modules and must respect the flags
  a_no_overflow : assert property (@(posedge IF_clk) disable iff (IF_rst) wr_req |-> !full)
    else $error("word_fifo write while full");
  a_no_underflow : assert property (@(posedge IF_clk) disable iff (IF_rst) rd_req |-> !empty)
    else $error("word_fifo read while empty");

endmodule

/* src/burst_timer.sv */
`timescale 1ns/10ps

module burst_timer
#(
  parameter int RX_BURST = 4,
  parameter int TX_BURST = 4,
  parameter int SP_BURST = 2
)
(
  input  logic                 IF_clk,
  input  logic                 IF_rst,
  input  fx2_pkg::fx2_state_t  state,
  input  fx2_pkg::ep_sel_t     ep_sel,
  output logic                 last
);

  localparam int MAX_AB = (RX_BURST > TX_BURST) ? RX_BURST : TX_BURST;
  localparam int MAX_B  = (MAX_AB > SP_BURST) ? MAX_AB : SP_BURST;
  localparam int CW     = $clog2(MAX_B + 1);    // count runs up to the burst length

  localparam logic [CW-1:0] RX_END = CW'(RX_BURST - 1);   // index of final word
  localparam logic [CW-1:0] TX_END = CW'(TX_BURST - 1);
  localparam logic [CW-1:0] SP_END = CW'(SP_BURST - 1);

  logic [CW-1:0] count;                         // words finished in this burst
  logic [CW-1:0] end_sel;                       // active limit
  logic          rx_phase;

  assign rx_phase = state inside {fx2_pkg::f1, fx2_pkg::f2, fx2_pkg::f3,
                                  fx2_pkg::f4, fx2_pkg::f5, fx2_pkg::f6};

  always_comb
  begin
    if (rx_phase)
      end_sel = RX_END;
    else if (ep_sel == fx2_pkg::ep_tx)
      end_sel = TX_END;
    else
      end_sel = SP_END;
  end

  assign last = (count == end_sel);             // sampled only at f6 and t7

  always_ff @(posedge IF_clk)
  begin
    if (IF_rst)
      count <= '0;
    else if (state inside {fx2_pkg::from_check, fx2_pkg::to_check,
                           fx2_pkg::fdone, fx2_pkg::tdone})
      count <= '0;                              // fresh burst
    else if (state inside {fx2_pkg::f6, fx2_pkg::t7})
      count <= count + 1'b1;                    // word done
  end

  // the state machine must leave the burst once last was seen
  a_count_in_limit : assert property (@(posedge IF_clk) disable iff (IF_rst)
    (state inside {fx2_pkg::f1, fx2_pkg::f6, fx2_pkg::t1, fx2_pkg::t7}) |-> count <= end_sel)
    else $error("burst count passed its limit");

endmodule

/* src/fx2_fifo_sm.sv */
`timescale 1ns/10ps

module fx2_fifo_sm
#(
  parameter int FIFO_DEPTH = 16,
  parameter int RX_BURST   = 4,
  parameter int TX_BURST   = 4,
  parameter int SP_BURST   = 2
)
(
  input  logic                 IF_clk,
  input  logic                 IF_rst,
  input  logic                 flaga,           // host has data for us
  input  logic                 flagb,           // ep4 has space
  input  logic                 flagc,           // ep6 has space
  output logic                 slrd,            // active low
  output logic                 slwr,            // active low
  output logic                 sloe,            // active low
  output fx2_pkg::fifo_adr_t   fifo_adr,
  input  fx2_pkg::usb_word_t   fd_in,
  output fx2_pkg::usb_word_t   fd_out,
  output logic                 fd_oe,
  fifo_link_if.wr_user         rx,
  fifo_link_if.rd_user         tx,
  fifo_link_if.rd_user         sp,
  output fx2_pkg::fx2_state_t  state,
  output fx2_pkg::ep_sel_t     ep_sel,
  input  logic                 last             // final word of the burst
);

  localparam int UW = $clog2(FIFO_DEPTH + 1);

  localparam logic [UW-1:0] RX_ROOM = UW'(FIFO_DEPTH - RX_BURST);   // max used before a burst
  localparam logic [UW-1:0] TX_MIN  = UW'(TX_BURST);
  localparam logic [UW-1:0] SP_MIN  = UW'(SP_BURST);

  fx2_pkg::fx2_state_t state_nxt;
  logic                rx_rdy;
  logic                to_rdy;

  ////////////////////////////////////////////////////////////////////////////
  // readiness and next state
  ////////////////////////////////////////////////////////////////////////////

  assign rx_rdy = flaga && (rx.used <= RX_ROOM);                   // full burst fits
  assign to_rdy = (ep_sel == fx2_pkg::ep_tx) ? (flagc && (tx.used >= TX_MIN))
                                             : (flagb && (sp.used >= SP_MIN));

  always_comb
  begin
    case (state)
      fx2_pkg::idle:       state_nxt = fx2_pkg::from_addr;
      fx2_pkg::from_addr:  state_nxt = fx2_pkg::from_check;    // ep2 address settling
      fx2_pkg::from_check: state_nxt = rx_rdy ? fx2_pkg::f1 : fx2_pkg::fdone;
      fx2_pkg::f1:         state_nxt = fx2_pkg::f2;
      fx2_pkg::f2:         state_nxt = fx2_pkg::f3;
      fx2_pkg::f3:         state_nxt = fx2_pkg::f4;
      fx2_pkg::f4:         state_nxt = fx2_pkg::f5;
      fx2_pkg::f5:         state_nxt = fx2_pkg::f6;
      fx2_pkg::f6:         state_nxt = last ? fx2_pkg::fdone : fx2_pkg::f1;
      fx2_pkg::fdone:      state_nxt = fx2_pkg::to_addr;
      fx2_pkg::to_addr:    state_nxt = fx2_pkg::to_check;      // ep4/ep6 address settling
      fx2_pkg::to_check:   state_nxt = to_rdy ? fx2_pkg::t1 : fx2_pkg::tdone;
      fx2_pkg::t1:         state_nxt = fx2_pkg::t2;
      fx2_pkg::t2:         state_nxt = fx2_pkg::t3;
      fx2_pkg::t3:         state_nxt = fx2_pkg::t4;
      fx2_pkg::t4:         state_nxt = fx2_pkg::t5;
      fx2_pkg::t5:         state_nxt = fx2_pkg::t6;
      fx2_pkg::t6:         state_nxt = fx2_pkg::t7;
      fx2_pkg::t7:         state_nxt = last ? fx2_pkg::tdone : fx2_pkg::t1;
      fx2_pkg::tdone:      state_nxt = fx2_pkg::from_addr;
      default:             state_nxt = fx2_pkg::idle;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // registered strobes, address and requests
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge IF_clk)
  begin
    if (IF_rst)
    begin
      state    <= fx2_pkg::idle;
      slrd     <= 1'b1;
      slwr     <= 1'b1;
      sloe     <= 1'b1;
      fd_oe    <= 1'b0;
      ep_sel   <= fx2_pkg::ep_tx;               // transmit goes first
      fifo_adr <= fx2_pkg::ep2_adr;
      rx.req   <= 1'b0;
      tx.req   <= 1'b0;
      sp.req   <= 1'b0;
    end
    else
    begin
      state <= state_nxt;
      if (state == fx2_pkg::f1)
        sloe <= 1'b0;                           // held through the read burst
      else if (state == fx2_pkg::fdone)
        sloe <= 1'b1;
      slrd <= !(state inside {fx2_pkg::f2, fx2_pkg::f3, fx2_pkg::f4});   // 3 clocks low
      slwr <= !(state inside {fx2_pkg::t1, fx2_pkg::t2, fx2_pkg::t3});   // 3 low, 4 high
      if (state == fx2_pkg::t1)
        fd_oe <= 1'b1;                          // drive bus for the write burst
      else if (state == fx2_pkg::tdone)
        fd_oe <= 1'b0;
      if (state == fx2_pkg::tdone)
        ep_sel <= (ep_sel == fx2_pkg::ep_tx) ? fx2_pkg::ep_sp : fx2_pkg::ep_tx;
      if (state inside {fx2_pkg::idle, fx2_pkg::tdone})
        fifo_adr <= fx2_pkg::ep2_adr;
      else if (state == fx2_pkg::fdone)
        fifo_adr <= (ep_sel == fx2_pkg::ep_tx) ? fx2_pkg::ep6_adr : fx2_pkg::ep4_adr;
      rx.req <= (state == fx2_pkg::f5);         // data captured a cycle earlier
      tx.req <= (state == fx2_pkg::t1) && (ep_sel == fx2_pkg::ep_tx);  // fetch ahead of slwr
      sp.req <= (state == fx2_pkg::t1) && (ep_sel == fx2_pkg::ep_sp);
    end
  end

  // host word is stable well before the end of f4
  always_ff @(posedge IF_clk)
  begin
    if (state == fx2_pkg::f4)
      rx.data <= fx2_pkg::byte_swap(fd_in);
  end

  // source word back into controller byte order
  assign fd_out = (ep_sel == fx2_pkg::ep_tx) ? fx2_pkg::byte_swap(tx.data)
                                             : fx2_pkg::byte_swap(fx2_pkg::usb_word_t'(sp.data));

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  a_strobe_excl : assert property (@(posedge IF_clk) disable iff (IF_rst) !(!slrd && !slwr))
    else $error("slrd and slwr low together");
  a_bus_contention : assert property (@(posedge IF_clk) disable iff (IF_rst) !(fd_oe && !sloe))
    else $error("fd_oe high while controller drives the bus");
  a_rx_room : assert property (@(posedge IF_clk) disable iff (IF_rst) rx.req |-> !rx.full)
    else $error("rx request on full receive fifo");

endmodule

/* src/fx2_usb_bridge.sv */
`timescale 1ns/10ps

module fx2_usb_bridge
#(
  parameter int FIFO_DEPTH = 16,
  parameter int RX_BURST   = 4,
  parameter int TX_BURST   = 4,
  parameter int SP_BURST   = 2
)
(
  input  logic                  IF_clk,
  input  logic                  IF_rst,
  input  logic                  flaga,          // controller side
  input  logic                  flagb,
  input  logic                  flagc,
  output logic                  slrd,
  output logic                  slwr,
  output logic                  sloe,
  output fx2_pkg::fifo_adr_t    fifo_adr,
  input  fx2_pkg::usb_word_t    fd_in,
  output fx2_pkg::usb_word_t    fd_out,
  output logic                  fd_oe,
  input  logic                  rx_rd,          // fabric side, host data out
  output fx2_pkg::usb_word_t    rx_data,
  output logic                  rx_empty,
  input  logic                  tx_wr,          // fabric side, words to host
  input  fx2_pkg::usb_word_t    tx_data,
  output logic                  tx_full,
  input  logic                  sp_wr,          // fabric side, spectrum to host
  input  fx2_pkg::spec_sample_t sp_data,
  output logic                  sp_full
);

  fx2_pkg::fx2_state_t state;
  fx2_pkg::ep_sel_t    ep_sel;
  logic                last;

  fifo_link_if #(.payload_t(fx2_pkg::usb_word_t),    .DEPTH(FIFO_DEPTH)) rx_link ();
  fifo_link_if #(.payload_t(fx2_pkg::usb_word_t),    .DEPTH(FIFO_DEPTH)) tx_link ();
  fifo_link_if #(.payload_t(fx2_pkg::spec_sample_t), .DEPTH(FIFO_DEPTH)) sp_link ();

  assign tx_full = tx_link.full;
  assign sp_full = sp_link.full;

  fx2_fifo_sm #(.FIFO_DEPTH(FIFO_DEPTH), .RX_BURST(RX_BURST), .TX_BURST(TX_BURST),
                .SP_BURST(SP_BURST)) u_sm
  (
    .IF_clk, .IF_rst, .flaga, .flagb, .flagc, .slrd, .slwr, .sloe, .fifo_adr,
    .fd_in, .fd_out, .fd_oe,
    .rx(rx_link.wr_user), .tx(tx_link.rd_user), .sp(sp_link.rd_user),
    .state, .ep_sel, .last
  );

  burst_timer #(.RX_BURST(RX_BURST), .TX_BURST(TX_BURST), .SP_BURST(SP_BURST)) u_timer
  (
    .IF_clk, .IF_rst, .state, .ep_sel, .last
  );

  // host words, written by the state machine
  word_fifo #(.payload_t(fx2_pkg::usb_word_t), .DEPTH(FIFO_DEPTH)) rx_fifo
  (
    .IF_clk, .IF_rst,
    .wr_req(rx_link.req), .wr_data(rx_link.data), .full(rx_link.full),
    .rd_req(rx_rd), .rd_data(rx_data), .empty(rx_empty), .used(rx_link.used)
  );

  word_fifo #(.payload_t(fx2_pkg::usb_word_t), .DEPTH(FIFO_DEPTH)) tx_fifo
  (
    .IF_clk, .IF_rst,
    .wr_req(tx_wr), .wr_data(tx_data), .full(tx_link.full),
    .rd_req(tx_link.req), .rd_data(tx_link.data), .empty(), .used(tx_link.used)
  );

  word_fifo #(.payload_t(fx2_pkg::spec_sample_t), .DEPTH(FIFO_DEPTH)) sp_fifo
  (
    .IF_clk, .IF_rst,
    .wr_req(sp_wr), .wr_data(sp_data), .full(sp_link.full),
    .rd_req(sp_link.req), .rd_data(sp_link.data), .empty(), .used(sp_link.used)
  );

endmodule

/* tests/fx2_usb_bridge_tb.sv */
`timescale 1ns/10ps

module fx2_usb_bridge_tb;

  localparam int FIFO_DEPTH = 8;                // small so the host words overfill it
  localparam int RX_BURST   = 4;
  localparam int TX_BURST   = 4;
  localparam int SP_BURST   = 2;

  logic IF_clk, IF_rst, flaga, flagb, flagc, slrd, slwr, sloe, fd_oe;
  logic rx_rd, rx_empty, tx_wr, tx_full, sp_wr, sp_full;
  fx2_pkg::fifo_adr_t    fifo_adr;
  fx2_pkg::usb_word_t    fd_in, fd_out, rx_data, tx_data;
  fx2_pkg::spec_sample_t sp_data;

  fx2_pkg::usb_word_t    host_q[$], tx_src_q[$], texp_q[$], sent_q[$];
  fx2_pkg::spec_sample_t sp_src_q[$], sexp_q[$];
  fx2_pkg::fifo_adr_t    sent_adr_q[$], run_adr;
  int phase_q[$];
  int host_idx = 0, host_on = 0, rd_low = 0, wr_low = 0, rd_falls = 0, wr_falls = 0;
  int run_len = 0, cycles = 0, limit = 1000000;
  logic slrd_q = 1'b1, slwr_q = 1'b1;

  fx2_usb_bridge #(.FIFO_DEPTH(FIFO_DEPTH), .RX_BURST(RX_BURST), .TX_BURST(TX_BURST),
                   .SP_BURST(SP_BURST)) uut
  (
    .IF_clk, .IF_rst, .flaga, .flagb, .flagc, .slrd, .slwr, .sloe, .fifo_adr,
    .fd_in, .fd_out, .fd_oe, .rx_rd, .rx_data, .rx_empty, .tx_wr, .tx_data, .tx_full,
    .sp_wr, .sp_data, .sp_full
  );

  initial
  begin
    IF_clk = 1'b0;
    forever #5 IF_clk = ~IF_clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("CHECKS FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_word(input fx2_pkg::usb_word_t got, exp, input string what);
    if (got !== exp)
    begin
      $display("ERR %0t %s: got %h expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_sample(input fx2_pkg::spec_sample_t got, exp, input string what);
    if (got !== exp)
    begin
      $display("ERR %0t %s: got bin %h mag %h expected bin %h mag %h", $time, what,
               got.bin, got.mag, exp.bin, exp.mag);
      abort_run();
    end
  endtask

  task automatic check_adr(input fx2_pkg::fifo_adr_t got, exp, input string what);
    if (got !== exp)
    begin
      $display("ERR %0t %s: got %b expected %b", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_bit(input logic got, exp, input string what);
    if (got !== exp)
    begin
      $display("ERR %0t %s: got %b expected %b", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_count(input int got, exp, input string what);
    if (got != exp)
    begin
      $display("ERR %0t %s: got %0d expected %0d", $time, what, got, exp);
      abort_run();
    end
  endtask

  function automatic fx2_pkg::usb_word_t swap_bytes(input fx2_pkg::usb_word_t w);
    return (w << 8) | (w >> 8);                 // controller side has bytes exchanged
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // controller bus model
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge IF_clk)
  begin
    #1;
    fd_in = (!sloe && host_idx < host_q.size()) ? host_q[host_idx] : '0;
    flaga = (host_on != 0) && (host_idx < host_q.size());
  end

  always @(negedge IF_clk)                      // strobes are stable mid cycle
  begin
    if (!IF_rst)
    begin
      if (!slrd)
      begin
        rd_falls += slrd_q ? 1 : 0;
        rd_low++;
      end
      else if (!slrd_q)
      begin
        check_count(rd_low, 3, "slrd low width");
        check_bit(sloe, 1'b0, "sloe at slrd rise");
        check_adr(fifo_adr, fx2_pkg::ep2_adr, "fifo_adr during read");
        rd_low = 0;
        host_idx++;                             // word taken, show the next
      end
      if (!slwr)
      begin
        wr_falls += slwr_q ? 1 : 0;
        wr_low++;
      end
      else if (!slwr_q)
      begin
        check_count(wr_low, 3, "slwr low width");
        check_bit(fd_oe, 1'b1, "fd_oe at slwr rise");
        wr_low = 0;
        sent_q.push_back(fd_out);
        sent_adr_q.push_back(fifo_adr);
      end
    end
    slrd_q = slrd;
    slwr_q = slwr;
  end

  always @(posedge IF_clk)
  begin
    cycles++;
    if (cycles > limit)
    begin
      $display("timeout: the run did not finish within %0d cycles", limit);
      abort_run();
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // phases
  ////////////////////////////////////////////////////////////////////////////

  task automatic tick();
    @(posedge IF_clk);
    #1;
  endtask

  task automatic load_tx(input int n);
    repeat (n)
    begin
      check_bit(tx_full, 1'b0, "tx_full while loading");
      tx_data = tx_src_q.pop_front();
      texp_q.push_back(tx_data);
      tx_wr = 1'b1;
      tick();
      tx_wr = 1'b0;
    end
  endtask

  task automatic load_sp(input int n);
    repeat (n)
    begin
      check_bit(sp_full, 1'b0, "sp_full while loading");
      sp_data = sp_src_q.pop_front();
      sexp_q.push_back(sp_data);
      sp_wr = 1'b1;
      tick();
      sp_wr = 1'b0;
    end
  endtask

  task automatic close_run();
    if (run_len != 0)                           // each burst run has its exact length
      check_count(run_len, (run_adr == fx2_pkg::ep6_adr) ? TX_BURST : SP_BURST, "burst run");
    run_len = 0;
  endtask

  task automatic drain_sent(input int n);
    fx2_pkg::usb_word_t w;
    fx2_pkg::fifo_adr_t a;
    while (sent_q.size() < n)
      tick();
    while (sent_q.size() > 0)
    begin
      w = sent_q.pop_front();
      a = sent_adr_q.pop_front();
      if (run_len != 0 && a != run_adr)
        close_run();
      run_adr = a;
      run_len++;
      if (a == fx2_pkg::ep6_adr)
        check_word(w, swap_bytes(texp_q.pop_front()), "transmit word");
      else
      begin
        check_adr(a, fx2_pkg::ep4_adr, "spectrum address");
        check_sample(fx2_pkg::spec_sample_t'(swap_bytes(w)), sexp_q.pop_front(), "sample");
      end
    end
  endtask

  task automatic host_read();
    int falls;
    host_on = 1;
    while (host_idx < FIFO_DEPTH)
      tick();
    falls = rd_falls;
    repeat (100) tick();                        // receive fifo full, reads must hold
    check_count(rd_falls - falls, 0, "slrd falls with full receive fifo");
    check_count(host_idx, FIFO_DEPTH, "host words taken");
    foreach (host_q[i])
    begin
      while (rx_empty)
        tick();
      rx_rd = 1'b1;
      tick();
      rx_rd = 1'b0;
      check_word(rx_data, swap_bytes(host_q[i]), "rx_data");
    end
    check_bit(rx_empty, 1'b1, "rx_empty after draining");
    host_on = 0;
  endtask

  task automatic hold_sources();
    int falls;
    load_tx(TX_BURST - 1);                      // one short of a burst
    load_sp(SP_BURST);                          // full, but its endpoint has no room
    flagc = 1'b1;
    falls = wr_falls;
    repeat (200) tick();
    check_count(wr_falls - falls, 0, "slwr falls with no ready source");
  endtask

  initial
  begin
    int fd, n, val;
    byte kind;
    string line;
    {IF_rst, flaga, flagb, flagc, rx_rd, tx_wr, sp_wr} = 7'b1000000;
    fd_in = '0;
    tx_data = '0;
    sp_data = '0;
    fd = $fopen("tests/fx2_stimulus.txt", "r");
    if (fd == 0)
    begin
      $display("cannot open tests/fx2_stimulus.txt");
      abort_run();
    end
    while (!$feof(fd))
    begin
      n = $fgets(line, fd);
      if (n > 0 && $sscanf(line, "%c %h", kind, val) == 2)
        case (kind)
          "H": host_q.push_back(fx2_pkg::usb_word_t'(val));
          "T": tx_src_q.push_back(fx2_pkg::usb_word_t'(val));
          "S": sp_src_q.push_back(fx2_pkg::spec_sample_t'(val[15:0]));
          "F": phase_q.push_back(val);
          default: ;                            // column notes
        endcase
    end
    $fclose(fd);
    limit = 40 * (host_q.size() + tx_src_q.size() + sp_src_q.size()) + 500;
    repeat (16)
    begin
      tick();
      check_bit(slrd, 1'b1, "slrd in reset");
      check_bit(slwr, 1'b1, "slwr in reset");
      check_bit(sloe, 1'b1, "sloe in reset");
      check_bit(fd_oe, 1'b0, "fd_oe in reset");
    end
    IF_rst = 1'b0;
    tick();
    check_bit(slrd, 1'b1, "slrd after reset");
    check_bit(slwr, 1'b1, "slwr after reset");
    check_bit(sloe, 1'b1, "sloe after reset");
    check_bit(fd_oe, 1'b0, "fd_oe after reset");
    check_bit(rx_empty, 1'b1, "rx_empty after reset");
    check_bit(tx_full, 1'b0, "tx_full after reset");
    check_bit(sp_full, 1'b0, "sp_full after reset");
    check_adr(fifo_adr, fx2_pkg::ep2_adr, "fifo_adr after reset");
    foreach (phase_q[i])
      case (phase_q[i])
        1:
        begin
          repeat (200) tick();
          check_count(rd_falls + wr_falls, 0, "strobe falls while idle");
        end
        2: host_read();
        3:
        begin
          load_tx(TX_BURST);
          flagc = 1'b1;
          drain_sent(TX_BURST);
          close_run();
          flagc = 1'b0;
        end
        4: hold_sources();
        5:
        begin
          load_tx(1);                           // completes the short burst
          flagb = 1'b1;
          drain_sent(TX_BURST + SP_BURST);
          close_run();
          {flagb, flagc} = 2'b00;
        end
        default:
        begin
          $display("unknown scenario code %0d in stimulus file", phase_q[i]);
          abort_run();
        end
      endcase
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

/* tests/fx2_stimulus.txt */
# columns: kind letter then a 16-bit hex value
# kinds: H host word, T transmit word, S spectrum bin/mag, F scenario
F 0001
H 1234
H 5678
H 9abc
H def0
H 0f1e
H 2d3c
H 4b5a
H 6978
H 8796
H a5b4
H c3d2
H e1f0
T a1b2
T c3d4
T e5f6
T 0718
T 293a
T 4b5c
T 6d7e
T 8f90
S 0310
S 07a4
F 0002
F 0003
F 0004
F 0005

/* fx2_usb_bridge.f */
src/fx2_pkg.sv
src/fifo_link_if.sv
src/word_fifo.sv
src/burst_timer.sv
src/fx2_fifo_sm.sv
src/fx2_usb_bridge.sv
tests/fx2_usb_bridge_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= fx2_usb_bridge_tb
FLIST     ?= fx2_usb_bridge.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
